// ==== Bender.yml ====
package:
  name: snake

sources:
  - snake_pkg.sv
  - button_cond.sv
  - tick_gen.sv
  - snake_walker.sv
  - game_sequencer.sv
  - segment_display.sv
  - snake_top.sv
  - target: test
    files:
      - tb_snake_top.sv

// ==== button_cond.sv ====
`timescale 1ns/1ns
`default_nettype none

module button_cond (
    input  wire  clk,
    input  wire  rst,
    input  wire  pb,
    output logic press
);

    import snake_pkg::*;

    logic [DEBOUNCE_LEN-1:0] shift_q;
    logic                    stable;
    logic                    stable_d;

    // Stable once every sample in the window is high
    assign stable = &shift_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shift_q  <= '0;
            stable_d <= 1'b0;
            press    <= 1'b0;
        end else begin
            shift_q  <= {shift_q[DEBOUNCE_LEN-2:0], pb};
            stable_d <= stable;
            // Rising edge of the debounced level
            press    <= stable & ~stable_d;
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
snake_pkg.sv
button_cond.sv
tick_gen.sv
snake_walker.sv
game_sequencer.sv
segment_display.sv
snake_top.sv
tb_snake_top.sv

// ==== game_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_sequencer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     slow_tick,
    input  wire                     press_down,
    input  wire snake_pkg::seg_idx_t seg,
    output snake_pkg::game_state_t  state,
    output snake_pkg::seg_mask_t    visited,
    output logic                    hold,
    output logic                    init,
    output logic                    move,
    output logic                    fall
);

    import snake_pkg::*;

    game_state_t state_next;
    tick_cnt_t   tick_cnt;
    seg_mask_t   seg_bit;
    logic        all_visited;
    logic        count_en;

    assign seg_bit     = seg_mask_t'(1) << seg;
    assign all_visited = &visited;

    // Ticks count while waiting to start and after the digit is full
    assign count_en = (state == INITIAL) || (state == FALLING && all_visited);

    always_comb begin
        state_next = state;
        case (state)
            INITIAL: begin
                if (slow_tick && tick_cnt == tick_cnt_t'(INIT_TICKS - 1)) begin
                    state_next = MOVING;
                end
            end
            MOVING: begin
                if (press_down) begin
                    state_next = FALLING;
                end
            end
            FALLING: begin
                if (all_visited && slow_tick &&
                    tick_cnt == tick_cnt_t'(FALL_HOLD_TICKS - 1)) begin
                    state_next = INITIAL;
                end
            end
            default: state_next = INITIAL;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= INITIAL;
            tick_cnt <= '0;
            visited  <= '0;
            hold     <= 1'b1;
            init     <= 1'b1;
            move     <= 1'b0;
            fall     <= 1'b0;
        end else begin
            state <= state_next;

            if (state_next != state) begin
                tick_cnt <= '0;
            end else if (count_en && slow_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end

            // Trail starts at the segment held when down was pressed
            if (state_next != FALLING) begin
                visited <= '0;
            end else if (state != FALLING) begin
                visited <= seg_bit;
            end else begin
                visited <= visited | seg_bit;
            end

            hold <= (state_next == INITIAL);
            init <= (state_next == INITIAL);
            move <= (state_next == MOVING);
            fall <= (state_next == FALLING);
        end
    end

endmodule

`default_nettype wire

// ==== segment_display.sv ====
`timescale 1ns/1ns
`default_nettype none

module segment_display (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      flash_tick,
    input  wire                      falling,
    input  wire snake_pkg::seg_idx_t  seg,
    input  wire snake_pkg::seg_mask_t visited,
    output snake_pkg::seg_mask_t     display
);

    import snake_pkg::*;

    seg_mask_t seg_bit;
    seg_mask_t lit;
    logic      flash_phase;

    assign seg_bit = seg_mask_t'(1) << seg;

    // Head segment blinks on top of the trail while falling
    always_comb begin
        if (!falling) begin
            lit = seg_bit;
        end else if (flash_phase) begin
            lit = visited & ~seg_bit;
        end else begin
            lit = visited | seg_bit;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flash_phase <= 1'b0;
            display     <= '1;
        end else begin
            if (!falling) begin
                flash_phase <= 1'b0;
            end else if (flash_tick) begin
                flash_phase <= ~flash_phase;
            end
            // Segments are active low
            display <= ~lit;
        end
    end

endmodule

`default_nettype wire

// ==== snake_pkg.sv ====
`default_nettype none

package snake_pkg;

    // Segment index and one-bit-per-segment mask, A is bit 0
    typedef logic [2:0] seg_idx_t;
    typedef logic [6:0] seg_mask_t;

    localparam int TICK_CNT_W = 8;
    typedef logic [TICK_CNT_W-1:0] tick_cnt_t;

    typedef enum logic [1:0] {
        RIGHT = 2'd0,
        LEFT  = 2'd1,
        UP    = 2'd2,
        DOWN  = 2'd3
    } heading_t;

    typedef enum logic [1:0] {
        INITIAL = 2'd0,
        MOVING  = 2'd1,
        FALLING = 2'd2
    } game_state_t;

    localparam seg_idx_t SEG_A = 3'd0;
    localparam seg_idx_t SEG_B = 3'd1;
    localparam seg_idx_t SEG_C = 3'd2;
    localparam seg_idx_t SEG_D = 3'd3;
    localparam seg_idx_t SEG_E = 3'd4;
    localparam seg_idx_t SEG_F = 3'd5;
    localparam seg_idx_t SEG_G = 3'd6;

    localparam seg_idx_t HOME_SEG     = SEG_G;
    localparam heading_t HOME_HEADING = LEFT;

    localparam int DEBOUNCE_LEN = 4;

    // Short tick periods so a simulation run stays brief
    localparam int SLOW_TICK_CYCLES  = 64;
    localparam int FLASH_TICK_CYCLES = 32;

    localparam int INIT_TICKS      = 3;
    localparam int FALL_HOLD_TICKS = 1;

endpackage

`default_nettype wire

// ==== snake_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module snake_top (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  right,
    input  wire                  left,
    input  wire                  up,
    input  wire                  down,
    output wire snake_pkg::seg_mask_t display,
    output wire                  init,
    output wire                  move,
    output wire                  fall,
    output wire snake_pkg::heading_t  pos
);

    import snake_pkg::*;

    wire         press_right;
    wire         press_left;
    wire         press_up;
    wire         press_down;
    wire         slow_tick;
    wire         flash_tick;
    wire         hold;
    seg_idx_t    seg;
    seg_mask_t   visited;

    button_cond u_btn_right (
        .clk   (clk),
        .rst   (rst),
        .pb    (right),
        .press (press_right)
    );

    button_cond u_btn_left (
        .clk   (clk),
        .rst   (rst),
        .pb    (left),
        .press (press_left)
    );

    button_cond u_btn_up (
        .clk   (clk),
        .rst   (rst),
        .pb    (up),
        .press (press_up)
    );

    button_cond u_btn_down (
        .clk   (clk),
        .rst   (rst),
        .pb    (down),
        .press (press_down)
    );

    tick_gen #(.PERIOD(SLOW_TICK_CYCLES)) u_slow_tick (
        .clk  (clk),
        .rst  (rst),
        .tick (slow_tick)
    );

    tick_gen #(.PERIOD(FLASH_TICK_CYCLES)) u_flash_tick (
        .clk  (clk),
        .rst  (rst),
        .tick (flash_tick)
    );

    snake_walker u_walker (
        .clk         (clk),
        .rst         (rst),
        .hold        (hold),
        .press_right (press_right),
        .press_left  (press_left),
        .press_up    (press_up),
        .seg         (seg),
        .heading     (pos)
    );

    game_sequencer u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .slow_tick  (slow_tick),
        .press_down (press_down),
        .seg        (seg),
        .state      (),
        .visited    (visited),
        .hold       (hold),
        .init       (init),
        .move       (move),
        .fall       (fall)
    );

    segment_display u_display (
        .clk        (clk),
        .rst        (rst),
        .flash_tick (flash_tick),
        .falling    (fall),
        .seg        (seg),
        .visited    (visited),
        .display    (display)
    );

endmodule

`default_nettype wire

// ==== snake_walker.sv ====
`timescale 1ns/1ns
`default_nettype none

module snake_walker (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  hold,
    input  wire                  press_right,
    input  wire                  press_left,
    input  wire                  press_up,
    output snake_pkg::seg_idx_t  seg,
    output snake_pkg::heading_t  heading
);

    import snake_pkg::*;

    seg_idx_t seg_next;
    heading_t heading_next;

    // Walk table, pairs not listed keep the position
    always_comb begin
        seg_next     = seg;
        heading_next = heading;
        case (seg)
            SEG_A: begin
                if (heading == RIGHT && press_right) begin
                    seg_next     = SEG_B;
                    heading_next = DOWN;
                end else if (heading == LEFT && press_left) begin
                    seg_next     = SEG_F;
                    heading_next = DOWN;
                end
            end
            SEG_B: begin
                if (heading == UP && press_left) begin
                    seg_next     = SEG_A;
                    heading_next = LEFT;
                end else if (heading == DOWN && press_right) begin
                    seg_next     = SEG_G;
                    heading_next = LEFT;
                end else if (heading == DOWN && press_up) begin
                    seg_next     = SEG_C;
                    heading_next = DOWN;
                end
            end
            SEG_C: begin
                if (heading == UP && press_left) begin
                    seg_next     = SEG_G;
                    heading_next = LEFT;
                end else if (heading == UP && press_up) begin
                    seg_next     = SEG_B;
                    heading_next = UP;
                end else if (heading == DOWN && press_right) begin
                    seg_next     = SEG_D;
                    heading_next = DOWN;
                end
            end
            SEG_D: begin
                if (heading == RIGHT && press_left) begin
                    seg_next     = SEG_C;
                    heading_next = UP;
                end else if (heading == LEFT && press_right) begin
                    seg_next     = SEG_E;
                    heading_next = UP;
                end
            end
            SEG_E: begin
                if (heading == UP && press_right) begin
                    seg_next     = SEG_G;
                    heading_next = RIGHT;
                end else if (heading == UP && press_up) begin
                    seg_next     = SEG_F;
                    heading_next = UP;
                end else if (heading == DOWN && press_left) begin
                    seg_next     = SEG_D;
                    heading_next = RIGHT;
                end
            end
            SEG_F: begin
                if (heading == UP && press_right) begin
                    seg_next     = SEG_A;
                    heading_next = RIGHT;
                end else if (heading == DOWN && press_left) begin
                    seg_next     = SEG_G;
                    heading_next = RIGHT;
                end
            end
            SEG_G: begin
                if (heading == RIGHT && press_left) begin
                    seg_next     = SEG_B;
                    heading_next = UP;
                end else if (heading == RIGHT && press_right) begin
                    seg_next     = SEG_C;
                    heading_next = DOWN;
                end else if (heading == LEFT && press_left) begin
                    seg_next     = SEG_E;
                    heading_next = DOWN;
                end else if (heading == LEFT && press_right) begin
                    seg_next     = SEG_F;
                    heading_next = UP;
                end
            end
            default: begin
                seg_next     = HOME_SEG;
                heading_next = HOME_HEADING;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seg     <= HOME_SEG;
            heading <= HOME_HEADING;
        end else if (hold) begin
            seg     <= HOME_SEG;
            heading <= HOME_HEADING;
        end else begin
            seg     <= seg_next;
            heading <= heading_next;
        end
    end

endmodule

`default_nettype wire

// ==== tb_snake_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_snake_top;

    import snake_pkg::*;

    localparam logic [1:0] BTN_RIGHT = 2'd0;
    localparam logic [1:0] BTN_LEFT  = 2'd1;
    localparam logic [1:0] BTN_UP    = 2'd2;
    localparam logic [1:0] BTN_DOWN  = 2'd3;

    // Rows before DOWN_ROW are moving, rows after it are falling
    localparam int NUM_ROWS = 17;
    localparam int DOWN_ROW = 10;

    logic      clk;
    logic      rst;
    logic      right;
    logic      left;
    logic      up;
    logic      down;
    seg_mask_t display;
    logic      init;
    logic      move;
    logic      fall;
    heading_t  pos;

    int unsigned seed_val;
    int          errors;

    // Row layout {button, expected heading, expected segment}
    logic [6:0] rows [0:NUM_ROWS-1];

    snake_top u_snake_top (
        .clk     (clk),
        .rst     (rst),
        .right   (right),
        .left    (left),
        .up      (up),
        .down    (down),
        .display (display),
        .init    (init),
        .move    (move),
        .fall    (fall),
        .pos     (pos)
    );

    always #20 clk = ~clk;

    function automatic logic [6:0] make_row(input logic [1:0] btn, input heading_t hdg,
                                            input seg_idx_t s);
        return {btn, hdg, s};
    endfunction

    // Display pins are low for every lit segment
    function automatic seg_mask_t active_low(input seg_mask_t lit);
        return ~lit;
    endfunction

    task automatic load_rows();
        rows[0]  = make_row(BTN_UP,    LEFT,  SEG_G);
        rows[1]  = make_row(BTN_RIGHT, UP,    SEG_F);
        rows[2]  = make_row(BTN_UP,    UP,    SEG_F);
        rows[3]  = make_row(BTN_RIGHT, RIGHT, SEG_A);
        rows[4]  = make_row(BTN_RIGHT, DOWN,  SEG_B);
        rows[5]  = make_row(BTN_RIGHT, LEFT,  SEG_G);
        rows[6]  = make_row(BTN_LEFT,  DOWN,  SEG_E);
        rows[7]  = make_row(BTN_LEFT,  RIGHT, SEG_D);
        rows[8]  = make_row(BTN_LEFT,  UP,    SEG_C);
        rows[9]  = make_row(BTN_LEFT,  LEFT,  SEG_G);
        // Down keeps the position and starts the trail
        rows[10] = make_row(BTN_DOWN,  LEFT,  SEG_G);
        rows[11] = make_row(BTN_LEFT,  DOWN,  SEG_E);
        rows[12] = make_row(BTN_LEFT,  RIGHT, SEG_D);
        rows[13] = make_row(BTN_LEFT,  UP,    SEG_C);
        rows[14] = make_row(BTN_UP,    UP,    SEG_B);
        rows[15] = make_row(BTN_LEFT,  LEFT,  SEG_A);
        rows[16] = make_row(BTN_LEFT,  DOWN,  SEG_F);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic drive_button(input logic [1:0] btn, input logic level);
        case (btn)
            BTN_RIGHT: right <= level;
            BTN_LEFT:  left  <= level;
            BTN_UP:    up    <= level;
            default:   down  <= level;
        endcase
    endtask

    task automatic apply_press(input logic [1:0] btn);
        int gap;
        @(posedge clk);
        drive_button(btn, 1'b1);
        repeat (8) @(posedge clk);
        drive_button(btn, 1'b0);
        repeat (8) @(posedge clk);
        gap = $urandom % 21;
        repeat (gap) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic wait_for_move(input int limit);
        int n;
        n = 0;
        while (!move && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!move) begin
            $display("Timeout: the game never entered the moving phase");
            errors++;
        end
    endtask

    task automatic wait_for_init(input int limit);
        int n;
        n = 0;
        while (!init && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!init) begin
            $display("Timeout: the game never returned to the initial phase");
            errors++;
        end
    endtask

    // Head must blink while the rest follows the trail
    task automatic watch_blink(input seg_mask_t head, input seg_mask_t trail);
        int   n;
        logic seen_lit;
        logic seen_dark;
        seen_lit  = 1'b0;
        seen_dark = 1'b0;
        for (n = 0; n < 2 * FLASH_TICK_CYCLES; n++) begin
            @(negedge clk);
            if ((display & head) == '0) seen_lit = 1'b1;
            else seen_dark = 1'b1;
            check("display_trail", display & ~head, active_low(trail | head));
        end
        if (!(seen_lit && seen_dark)) begin
            $display("Current segment did not blink while falling");
            errors++;
        end
    endtask

    initial begin
        int        i;
        logic [1:0] btn;
        heading_t  exp_hdg;
        seg_idx_t  exp_seg;
        seg_mask_t head;
        seg_mask_t visited_model;
        errors   = 0;
        seed_val = $urandom(32'h6d98);
        clk      = 1'b0;
        rst      = 1'b1;
        right    = 1'b0;
        left     = 1'b0;
        up       = 1'b0;
        down     = 1'b0;
        visited_model = '0;
        load_rows();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check("init", init, 1);
        check("move", move, 0);
        check("fall", fall, 0);
        check("pos", pos, LEFT);
        check("display", display, active_low(seg_mask_t'(1) << SEG_G));
        wait_for_move((INIT_TICKS + 2) * SLOW_TICK_CYCLES);
        @(negedge clk);
        check("pos", pos, LEFT);
        check("display", display, active_low(seg_mask_t'(1) << SEG_G));
        for (i = 0; i < NUM_ROWS; i++) begin
            btn     = rows[i][6:5];
            exp_hdg = heading_t'(rows[i][4:3]);
            exp_seg = rows[i][2:0];
            head    = seg_mask_t'(1) << exp_seg;
            apply_press(btn);
            if (i < DOWN_ROW) begin
                check("move", move, 1);
                check("pos", pos, exp_hdg);
                check("display", display, active_low(head));
            end else if (i == DOWN_ROW) begin
                visited_model = head;
                check("fall", fall, 1);
                check("move", move, 0);
                check("pos", pos, exp_hdg);
                watch_blink(head, visited_model);
            end else if (i < NUM_ROWS - 1) begin
                visited_model = visited_model | head;
                check("fall", fall, 1);
                check("pos", pos, exp_hdg);
                check("display_trail", display & ~head, active_low(visited_model | head));
            end else begin
                // Digit is full, the game goes back home
                wait_for_init((FALL_HOLD_TICKS + 2) * SLOW_TICK_CYCLES);
                repeat (3) @(posedge clk);
                @(negedge clk);
                check("init", init, 1);
                check("fall", fall, 0);
                check("pos", pos, LEFT);
                check("display", display, active_low(seg_mask_t'(1) << SEG_G));
            end
        end
        $display("Error count: %0d", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tick_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tick_gen #(
    parameter int PERIOD = snake_pkg::SLOW_TICK_CYCLES
) (
    input  wire  clk,
    input  wire  rst,
    output logic tick
);

    import snake_pkg::*;

    tick_cnt_t cnt;

    assign tick = (cnt == tick_cnt_t'(PERIOD - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (tick) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire
